/* Makefile */
# Verilator build and run of the V850 core testbench

SIM := obj_dir/v850_core_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --assert --Mdir obj_dir -f v850_core.f \
		--top-module v850_core_tb -o v850_core_sim
	./$(SIM)

clean:
	rm -rf obj_dir

/* rtl/v850_core.sv */
`timescale 1ns/100ps

module v850_core import v850_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  instr_t     instr,
    output logic       retire,      // Two edges after instr_valid
    output logic       wb_en,
    output reg_idx_t   wb_reg,
    output word_t      wb_data,
    output psw_flags_t psw          // CY OV S Z
);

    // Decode to execute
    logic     dec_valid;
    alu_op_e  dec_op;
    reg_idx_t dec_reg1;
    reg_idx_t dec_reg2;
    word_t    dec_imm;
    logic     dec_use_imm;

    // Execute to register file reads
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    word_t    rd_data_a;
    word_t    rd_data_b;

    v850_decode v850_decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_reg1    (dec_reg1),
        .dec_reg2    (dec_reg2),
        .dec_imm     (dec_imm),
        .dec_use_imm (dec_use_imm)
    );

    v850_execute v850_execute_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_reg1    (dec_reg1),
        .dec_reg2    (dec_reg2),
        .dec_imm     (dec_imm),
        .dec_use_imm (dec_use_imm),
        .rd_idx_a    (rd_idx_a),
        .rd_idx_b    (rd_idx_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .retire      (retire),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .psw         (psw)
    );

    // Write port fed straight from the writeback registers
    v850_regfile v850_regfile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wb_en),
        .wr_idx    (wb_reg),
        .wr_data   (wb_data)
    );

endmodule

/* rtl/v850_decode.sv */
`timescale 1ns/100ps

module v850_decode import v850_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,   // At most one per cycle
    input  instr_t   instr,
    output logic     dec_valid,
    output alu_op_e  dec_op,
    output reg_idx_t dec_reg1,
    output reg_idx_t dec_reg2,      // Destination and second source
    output word_t    dec_imm,
    output logic     dec_use_imm    // Source is dec_imm instead of reg1
);

    opcode_t  opc;
    reg_idx_t fld_lo;               // reg1 or imm5, same bits
    alu_op_e  op_d;
    logic     use_imm_d;
    logic     shift_form;
    word_t    imm_d;

    assign opc    = instr[10:5];
    assign fld_lo = instr[4:0];

    // Opcode field to ALU operation
    always_comb begin
        op_d      = OP_NONE;
        use_imm_d = 1'b0;
        case (opc)
            OPC_MOV:  op_d = OP_MOV;
            OPC_NOT:  op_d = OP_NOT;
            OPC_OR:   op_d = OP_OR;
            OPC_XOR:  op_d = OP_XOR;
            OPC_AND:  op_d = OP_AND;
            OPC_TST:  op_d = OP_TST;
            OPC_SUBR: op_d = OP_SUBR;
            OPC_SUB:  op_d = OP_SUB;
            OPC_ADD:  op_d = OP_ADD;
            OPC_CMP:  op_d = OP_CMP;
            OPC_MOV_I: begin
                op_d      = OP_MOV;
                use_imm_d = 1'b1;
            end
            OPC_ADD_I: begin
                op_d      = OP_ADD;
                use_imm_d = 1'b1;
            end
            OPC_CMP_I: begin
                op_d      = OP_CMP;
                use_imm_d = 1'b1;
            end
            OPC_SHR_I: begin
                op_d      = OP_SHR;
                use_imm_d = 1'b1;
            end
            OPC_SAR_I: begin
                op_d      = OP_SAR;
                use_imm_d = 1'b1;
            end
            OPC_SHL_I: begin
                op_d      = OP_SHL;
                use_imm_d = 1'b1;
            end
            default:  op_d = OP_NONE;   // Everything else retires as no-op
        endcase
    end

    // Shift count is unsigned, the other imm5 forms are signed
    assign shift_form = (opc == OPC_SHR_I) || (opc == OPC_SAR_I) || (opc == OPC_SHL_I);
    assign imm_d      = shift_form ? {27'd0, fld_lo} : {{27{fld_lo[4]}}, fld_lo};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;       // One-cycle pulse per instruction
        end
    end

    // Fields only move on a valid instruction
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_op      <= op_d;
            dec_reg1    <= fld_lo;
            dec_reg2    <= instr[15:11];
            dec_imm     <= imm_d;
            dec_use_imm <= use_imm_d;
        end
    end

    // Execute must never see a floating operation
    a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> !$isunknown({dec_op, dec_use_imm}));

endmodule

/* rtl/v850_execute.sv */
`timescale 1ns/100ps

module v850_execute import v850_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dec_valid,
    input  alu_op_e    dec_op,
    input  reg_idx_t   dec_reg1,
    input  reg_idx_t   dec_reg2,
    input  word_t      dec_imm,
    input  logic       dec_use_imm,
    output reg_idx_t   rd_idx_a,
    output reg_idx_t   rd_idx_b,
    input  word_t      rd_data_a,
    input  word_t      rd_data_b,
    output logic       retire,
    output logic       wb_en,
    output reg_idx_t   wb_reg,
    output word_t      wb_data,
    output psw_flags_t psw
);

    word_t       src;               // reg1 or imm
    word_t       dst;               // reg2 value
    word_t       sub_a;
    word_t       sub_b;
    word_t       result;
    logic [4:0]  sh_amt;
    logic [32:0] add_full;          // Bit 32 is carry
    logic [32:0] sub_full;          // Bit 32 is borrow
    logic [32:0] shr_full;          // Bit 0 is last bit out
    logic [32:0] sar_full;
    logic [32:0] shl_full;          // Bit 32 is last bit out
    logic        cy_n;
    logic        ov_n;
    logic        flags_upd;
    logic        writes;
    psw_flags_t  psw_n;

    // Register file read in the same cycle as decode output
    assign rd_idx_a = dec_reg1;
    assign rd_idx_b = dec_reg2;

    assign src    = dec_use_imm ? dec_imm : rd_data_a;
    assign dst    = rd_data_b;
    assign sh_amt = dec_imm[4:0];

    assign add_full = {1'b0, dst} + {1'b0, src};

    // SUBR swaps the operands
    assign sub_a    = (dec_op == OP_SUBR) ? src : dst;
    assign sub_b    = (dec_op == OP_SUBR) ? dst : src;
    assign sub_full = {1'b0, sub_a} - {1'b0, sub_b};

    // Extra bit catches the carry out, zero for a count of zero
    assign shr_full = {dst, 1'b0} >> sh_amt;
    assign sar_full = $signed({dst, 1'b0}) >>> sh_amt;
    assign shl_full = {1'b0, dst} << sh_amt;

    always_comb begin
        result    = dst;
        cy_n      = psw[PSW_CY];    // Logic ops keep CY
        ov_n      = 1'b0;
        flags_upd = 1'b1;
        case (dec_op)
            OP_MOV: begin
                result    = src;
                flags_upd = 1'b0;
            end
            OP_NOT:         result = ~src;
            OP_OR:          result = dst | src;
            OP_XOR:         result = dst ^ src;
            OP_AND, OP_TST: result = dst & src;
            OP_ADD: begin
                result = add_full[31:0];
                cy_n   = add_full[32];
                ov_n   = (dst[31] == src[31]) && (add_full[31] != dst[31]);
            end
            OP_SUB, OP_SUBR, OP_CMP: begin
                result = sub_full[31:0];
                cy_n   = sub_full[32];
                ov_n   = (sub_a[31] != sub_b[31]) && (sub_full[31] != sub_a[31]);
            end
            OP_SHR: begin
                result = shr_full[32:1];
                cy_n   = shr_full[0];
            end
            OP_SAR: begin
                result = sar_full[32:1];    // Sign bit refilled
                cy_n   = sar_full[0];
            end
            OP_SHL: begin
                result = shl_full[31:0];
                cy_n   = shl_full[32];
            end
            default:        flags_upd = 1'b0;   // OP_NONE
        endcase
    end

    assign psw_n  = {cy_n, ov_n, result[31], result == '0};
    assign writes = !(dec_op inside {OP_CMP, OP_TST, OP_NONE});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire <= 1'b0;
            wb_en  <= 1'b0;
            psw    <= '0;
        end else begin
            retire <= dec_valid;
            wb_en  <= dec_valid && writes;
            if (dec_valid && flags_upd) begin
                psw <= psw_n;       // Same edge that raises retire
            end
        end
    end

    // Writeback payload
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            wb_reg  <= dec_reg2;
            wb_data <= result;
        end
    end

    // Exactly one retire per decoded instruction, one cycle later
    a_retire_follows: assert property (@(posedge clk) disable iff (!rst_n)
        retire |-> $past(dec_valid));

endmodule

/* rtl/v850_pkg.sv */
package v850_pkg;

    // Widths fixed by the V850 register/short-immediate formats
    typedef logic [31:0] word_t;        // GR and ALU value
    typedef logic [4:0]  reg_idx_t;     // r0..r31
    typedef logic [15:0] instr_t;       // One halfword, reg2 | opcode | reg1/imm5
    typedef logic [5:0]  opcode_t;      // Bits 10:5
    typedef logic [3:0]  psw_flags_t;   // PSW[3:0] = CY OV S Z

    // Flag positions inside psw_flags_t
    localparam int PSW_CY = 3;
    localparam int PSW_OV = 2;
    localparam int PSW_S  = 1;
    localparam int PSW_Z  = 0;

    // Operations seen by the execute stage
    typedef enum logic [3:0] {
        OP_MOV  = 4'd0,
        OP_NOT  = 4'd1,
        OP_OR   = 4'd2,
        OP_XOR  = 4'd3,
        OP_AND  = 4'd4,
        OP_TST  = 4'd5,     // AND without writeback
        OP_SUBR = 4'd6,     // reg1 - reg2
        OP_SUB  = 4'd7,     // reg2 - reg1
        OP_ADD  = 4'd8,
        OP_CMP  = 4'd9,     // SUB without writeback
        OP_SHR  = 4'd10,
        OP_SAR  = 4'd11,
        OP_SHL  = 4'd12,
        OP_NONE = 4'd15     // Unsupported code, retires as no-op
    } alu_op_e;

    // Format I, register operand
    localparam opcode_t OPC_MOV   = 6'b000000;   // MOV r0, r0 is NOP
    localparam opcode_t OPC_NOT   = 6'b000001;
    localparam opcode_t OPC_OR    = 6'b001000;
    localparam opcode_t OPC_XOR   = 6'b001001;
    localparam opcode_t OPC_AND   = 6'b001010;
    localparam opcode_t OPC_TST   = 6'b001011;
    localparam opcode_t OPC_SUBR  = 6'b001100;
    localparam opcode_t OPC_SUB   = 6'b001101;
    localparam opcode_t OPC_ADD   = 6'b001110;
    localparam opcode_t OPC_CMP   = 6'b001111;

    // Format II, imm5 operand
    localparam opcode_t OPC_MOV_I = 6'b010000;   // Signed imm5
    localparam opcode_t OPC_ADD_I = 6'b010010;
    localparam opcode_t OPC_CMP_I = 6'b010011;
    localparam opcode_t OPC_SHR_I = 6'b010100;   // Unsigned shift count
    localparam opcode_t OPC_SAR_I = 6'b010101;
    localparam opcode_t OPC_SHL_I = 6'b010110;

endpackage

/* rtl/v850_regfile.sv */
`timescale 1ns/100ps

module v850_regfile import v850_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_idx_a,      // reg1 port
    input  reg_idx_t rd_idx_b,      // reg2 port
    output word_t    rd_data_a,
    output word_t    rd_data_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [1:31];             // r0 has no storage

    logic hit_a;
    logic hit_b;

    // Write port forwarded to a read of the same index
    assign hit_a = wr_en && (wr_idx == rd_idx_a);
    assign hit_b = wr_en && (wr_idx == rd_idx_b);

    // r0 check first, so a write to r0 never shows through
    assign rd_data_a = (rd_idx_a == '0) ? '0 :
                       hit_a            ? wr_data :
                                          regs[rd_idx_a];

    assign rd_data_b = (rd_idx_b == '0) ? '0 :
                       hit_b            ? wr_data :
                                          regs[rd_idx_b];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;      // All GRs start at zero
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // r0 reads zero even while a write to r0 is on the port
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_idx_a == '0) |-> (rd_data_a == '0));

endmodule

/* testbench/v850_core_tb.sv */
`timescale 1ns/100ps

module v850_core_tb import v850_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;       // Held in reset from time zero
    logic       instr_valid = 1'b0;
    instr_t     instr = '0;
    logic       retire;
    logic       wb_en;
    reg_idx_t   wb_reg;
    word_t      wb_data;
    psw_flags_t psw;

    // Stimulus table, one entry per instruction
    instr_t     tab_instr[$];
    logic       tab_en[$];          // Expected wb_en
    reg_idx_t   tab_reg[$];
    word_t      tab_data[$];
    psw_flags_t tab_psw[$];         // CY OV S Z after retire

    // In-flight bookkeeping, filled at issue and drained at retire
    int          pend_row[$];
    int          pend_due[$];       // Negedge count when retire is due
    int          cur_row = 0;
    int          edge_cnt = 0;
    logic [31:0] rng_state = 32'hea5b;

    v850_core v850_core_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .psw         (psw)
    );

    initial begin
        forever #20 clk = ~clk;     // 40 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Halfword layout: reg2 | opcode | reg1 or imm5
    function automatic instr_t enc(input opcode_t opc, input reg_idx_t r2, input logic [4:0] lo);
        return {r2, opc, lo};
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: expected 0x%08h, got 0x%08h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic add_row(input instr_t ins, input logic en, input reg_idx_t r,
                           input word_t d, input psw_flags_t p);
        tab_instr.push_back(ins);
        tab_en.push_back(en);
        tab_reg.push_back(r);
        tab_data.push_back(d);
        tab_psw.push_back(p);
    endtask

    // Expected values worked out by hand, starting from reset state
    task automatic build_table();
        // Dependent chain, each result forwarded to the next row
        add_row(enc(OPC_MOV_I, 5'd1, 5'd5),    1'b1, 5'd1, 32'h0000_0005, 4'h0);
        add_row(enc(OPC_SHL_I, 5'd1, 5'd4),    1'b1, 5'd1, 32'h0000_0050, 4'h0);
        add_row(enc(OPC_ADD,   5'd2, 5'd1),    1'b1, 5'd2, 32'h0000_0050, 4'h0);
        add_row(enc(OPC_ADD_I, 5'd2, 5'h1f),   1'b1, 5'd2, 32'h0000_004f, 4'h8); // + -1, carry
        // Build 0x7fffffff in r3 and r4
        add_row(enc(OPC_MOV_I, 5'd3, 5'h1f),   1'b1, 5'd3, 32'hffff_ffff, 4'h8);
        add_row(enc(OPC_SHR_I, 5'd3, 5'd1),    1'b1, 5'd3, 32'h7fff_ffff, 4'h8);
        add_row(enc(OPC_MOV,   5'd4, 5'd3),    1'b1, 5'd4, 32'h7fff_ffff, 4'h8);
        add_row(enc(OPC_ADD,   5'd4, 5'd3),    1'b1, 5'd4, 32'hffff_fffe, 4'h6); // OV and S
        add_row(enc(OPC_ADD_I, 5'd4, 5'd2),    1'b1, 5'd4, 32'h0000_0000, 4'h9); // Wrap, CY Z
        add_row(enc(OPC_MOV_I, 5'd5, 5'd3),    1'b1, 5'd5, 32'h0000_0003, 4'h9);
        add_row(enc(OPC_MOV_I, 5'd1, 5'd5),    1'b1, 5'd1, 32'h0000_0005, 4'h9); // r1 back to 5
        add_row(enc(OPC_SUB,   5'd5, 5'd2),    1'b1, 5'd5, 32'hffff_ffb4, 4'ha); // 3 - 0x4f
        add_row(enc(OPC_CMP_I, 5'd1, 5'd5),    1'b0, 5'd1, 32'h0000_0000, 4'h1); // Equal
        add_row(enc(OPC_CMP,   5'd1, 5'd2),    1'b0, 5'd1, 32'h0000_0000, 4'ha); // 5 - 0x4f
        add_row(enc(OPC_SUBR,  5'd1, 5'd2),    1'b1, 5'd1, 32'h0000_004a, 4'h0); // 0x4f - 5
        add_row(enc(OPC_CMP,   5'd3, 5'd5),    1'b0, 5'd3, 32'h0000_0000, 4'he); // CY OV S
        // Logic ops clear OV, CY carried over
        add_row(enc(OPC_AND,   5'd5, 5'd1),    1'b1, 5'd5, 32'h0000_0000, 4'h9);
        add_row(enc(OPC_OR,    5'd5, 5'd3),    1'b1, 5'd5, 32'h7fff_ffff, 4'h8);
        add_row(enc(OPC_XOR,   5'd5, 5'd2),    1'b1, 5'd5, 32'h7fff_ffb0, 4'h8);
        add_row(enc(OPC_NOT,   5'd6, 5'd5),    1'b1, 5'd6, 32'h8000_004f, 4'ha);
        // Shifts, CY is the last bit out
        add_row(enc(OPC_SAR_I, 5'd6, 5'd5),    1'b1, 5'd6, 32'hfc00_0002, 4'h2); // Sign kept
        add_row(enc(OPC_SHR_I, 5'd6, 5'd2),    1'b1, 5'd6, 32'h3f00_0000, 4'h8);
        add_row(enc(OPC_SHL_I, 5'd6, 5'd3),    1'b1, 5'd6, 32'hf800_0000, 4'ha);
        add_row(enc(OPC_SHL_I, 5'd6, 5'd0),    1'b1, 5'd6, 32'hf800_0000, 4'h2); // Zero count
        // Writes that must not land
        add_row(enc(6'b000010, 5'd1, 5'd2),    1'b0, 5'd1, 32'h0000_0000, 4'h2); // Not kept
        add_row(enc(OPC_MOV_I, 5'd0, 5'd7),    1'b1, 5'd0, 32'h0000_0007, 4'h2);
        add_row(enc(OPC_ADD,   5'd1, 5'd0),    1'b1, 5'd1, 32'h0000_004a, 4'h0); // r0 still 0
        add_row(enc(OPC_MOV,   5'd0, 5'd0),    1'b1, 5'd0, 32'h0000_0000, 4'h0); // NOP
        add_row(enc(OPC_TST,   5'd1, 5'd4),    1'b0, 5'd1, 32'h0000_0000, 4'h1);
        add_row(enc(OPC_MOV,   5'd7, 5'd1),    1'b1, 5'd7, 32'h0000_004a, 4'h1); // r1 intact
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Quiet pipeline straight after reset
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_word("retire", {31'd0, retire}, 32'd0);
            check_word("wb_en", {31'd0, wb_en}, 32'd0);
            check_word("psw", {28'd0, psw}, 32'd0);
        end
    endtask

    task automatic check_row(input int row);
        check_word("retire", {31'd0, retire}, 32'd1);
        check_word("wb_en", {31'd0, wb_en}, {31'd0, tab_en[row]});
        if (tab_en[row]) begin
            check_word("wb_reg", {27'd0, wb_reg}, {27'd0, tab_reg[row]});
            check_word("wb_data", wb_data, tab_data[row]);
        end
        check_word("psw", {28'd0, psw}, {28'd0, tab_psw[row]});
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (pend_row.size() != 0 && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (pend_row.size() != 0) begin
            $display("Timeout: issued instructions did not all retire");
            abort_run();
        end
    endtask

    // Whole table, back to back or with random idle gaps
    task automatic run_table(input logic gaps);
        int gap;
        for (int i = 0; i < tab_instr.size(); i++) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= tab_instr[i];
            cur_row     <= i;
            if (gaps) begin
                rng_state = xorshift32(rng_state);
                gap = int'(rng_state[1:0]);     // Zero to three idle cycles
                for (int g = 0; g < gap; g++) begin
                    @(posedge clk);
                    instr_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        wait_drained();
    endtask

    // Outputs sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (instr_valid) begin
                pend_row.push_back(cur_row);
                pend_due.push_back(edge_cnt + 2);   // Two edges of latency
            end
            if (pend_due.size() > 0 && pend_due[0] == edge_cnt) begin
                check_row(pend_row.pop_front());
                pend_due.delete(0);
            end else begin
                check_word("retire", {31'd0, retire}, 32'd0);   // Nothing due
                check_word("wb_en", {31'd0, wb_en}, 32'd0);
            end
        end
        edge_cnt++;
    end

    initial begin
        build_table();
        apply_reset();
        check_idle(4);
        run_table(1'b0);
        // Same table again from a fresh reset, now with gaps
        apply_reset();
        check_idle(4);
        run_table(1'b1);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* v850_core.f */
rtl/v850_pkg.sv
rtl/v850_decode.sv
rtl/v850_regfile.sv
rtl/v850_execute.sv
rtl/v850_core.sv
testbench/v850_core_tb.sv
